// ==== flist.f ====
source/da_pkg.sv
source/host_cmd_parser.sv
source/echo_fifo.sv
source/report_framer.sv
source/clock_select_regs.sv
source/slot_clock_ctrl.sv
source/da_core.sv
sim/tb_clock_gen.sv
sim/tb_da_core.sv

// ==== sim/tb_clock_gen.sv ====
//**********************************************************************
// Testbench clock and reset generator
// 4 ns core clock, synchronous reset held low for 8 cycles
//**********************************************************************

`timescale 1ns/1ps

module tb_clock_gen (
    output logic cr_core,
    output logic rst_n
);

    localparam real HALF_PERIOD = 2.0;
    localparam int RESET_CYCLES = 8;

    initial begin
        cr_core = 1'b0;
        forever #(HALF_PERIOD) cr_core = ~cr_core;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge cr_core);
        rst_n <= 1'b1;
    end

endmodule

// ==== sim/tb_da_core.sv ====
//**********************************************************************
// DA control core testbench
// Table of host packets with expected report frames, applied in a
// loop, plus checks of slot reset release and slot clock switching
//**********************************************************************

`timescale 1ns/1ps

module tb_da_core import da_pkg::*; ();

    localparam int NUM_TESTS = 8;
    localparam int KIND_REPORT = 0;
    localparam int KIND_SELECT = 1;
    localparam int KIND_SILENT = 2;
    localparam int FOLLOW_CYCLES = 30;

    logic           cr_core;
    logic           rst_n;
    logic           in_valid;
    host_word_t     in_data;
    logic [7:0]     dirchan;
    logic [7:0]     aovf;
    logic           clk0 = 1'b0;
    logic           clk1 = 1'b0;
    logic           out_valid;
    host_word_t     out_data;
    slot_mask_t     slot_clk;
    slot_mask_t     slot_reset;

    int             seed = 32'hae2b_c53e;
    int             cycles = 0;
    int             limit = 500;
    int             div0 = 0;
    int             div1 = 0;
    string          cur_name = "reset";

    // Test table with command and expected words packed into flat queues
    string          tname [NUM_TESTS];
    int             tkind [NUM_TESTS];
    int             cmd_base [NUM_TESTS];
    int             cmd_len [NUM_TESTS];
    int             exp_base [NUM_TESTS];
    int             exp_len [NUM_TESTS];
    slot_mask_t     tsel [NUM_TESTS];
    slot_mask_t     tchg [NUM_TESTS];
    host_word_t     cmd_words [$];
    host_word_t     exp_words [$];
    int             n_tests = 0;
    logic [31:0]    csum;
    slot_mask_t     model_sel = '0;

    tb_clock_gen u_clock_gen (
        .cr_core (cr_core),
        .rst_n   (rst_n)
    );

    da_core u_da_core (
        .cr_core    (cr_core),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .dirchan    (dirchan),
        .aovf       (aovf),
        .clk0       (clk0),
        .clk1       (clk1),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .slot_clk   (slot_clk),
        .slot_reset (slot_reset)
    );

    // Slow converter clocks with periods of 10 and 14 core cycles
    always @(posedge cr_core) begin
        if (!rst_n) begin
            div0 <= 0;
            div1 <= 0;
            clk0 <= 1'b0;
            clk1 <= 1'b0;
        end else begin
            div0 <= (div0 == 4) ? 0 : div0 + 1;
            div1 <= (div1 == 6) ? 0 : div1 + 1;
            if (div0 == 4) begin
                clk0 <= ~clk0;
            end
            if (div1 == 6) begin
                clk1 <= ~clk1;
            end
        end
    end

    always @(posedge cr_core) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("Run timed out after %0d cycles in test %s", cycles, cur_name);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] got);
        $display("FAIL %s: %s expected %0h actual %0h", cur_name, what, exp, got);
        abort_run();
    endtask

    task automatic report_error(input string text);
        $display("ERROR in %s: %s", cur_name, text);
        abort_run();
    endtask

    function automatic host_word_t random_word();
        return host_word_t'($random(seed));
    endfunction

    task automatic open_test(input string name, input int kind);
        tname[n_tests] = name;
        tkind[n_tests] = kind;
        cmd_base[n_tests] = cmd_words.size();
        exp_base[n_tests] = exp_words.size();
    endtask

    task automatic close_test();
        cmd_len[n_tests] = cmd_words.size() - cmd_base[n_tests];
        exp_len[n_tests] = exp_words.size() - exp_base[n_tests];
        n_tests++;
    endtask

    // Expected frame word and its share of the running checksum
    task automatic frame_word(input host_word_t w);
        exp_words.push_back(w);
        csum = csum + {16'h0000, w};
    endtask

    task automatic frame_header(input host_word_t slot, input host_word_t code,
                                input report_len_t len);
        csum = '0;
        frame_word(slot);
        frame_word(code);
        frame_word(host_word_t'(len[23:16]));
        frame_word(len[15:0]);
    endtask

    task automatic frame_footer();
        exp_words.push_back(csum[31:16]);
        exp_words.push_back(csum[15:0]);
    endtask

    task automatic add_status_test(input string name, input host_word_t cmd,
                                   input host_word_t code, input logic [7:0] stat);
        open_test(name, KIND_REPORT);
        cmd_words.push_back(random_word());
        cmd_words.push_back(cmd);
        frame_header(GLOBAL_TARGET_INDEX, code, report_len_t'(1));
        frame_word(host_word_t'(stat));
        frame_footer();
        close_test();
    endtask

    task automatic add_echo_test(input string name, input int n);
        host_word_t slot;
        host_word_t w;
        slot = random_word();
        open_test(name, KIND_REPORT);
        cmd_words.push_back(slot);
        cmd_words.push_back(ECHO_SEND);
        cmd_words.push_back(host_word_t'(n));
        frame_header(slot, ECHO_REPORT, report_len_t'(n));
        for (int i = 0; i < n; i++) begin
            w = random_word();
            cmd_words.push_back(w);
            frame_word(w);
        end
        frame_footer();
        close_test();
    endtask

    task automatic add_select_test(input string name);
        slot_mask_t new_sel;
        host_word_t w;
        new_sel = slot_mask_t'($random(seed));
        if (new_sel == model_sel) begin
            new_sel[0] = ~new_sel[0];
        end
        w = random_word();
        w[NUM_SLOTS-1:0] = new_sel;
        open_test(name, KIND_SELECT);
        tsel[n_tests] = new_sel;
        tchg[n_tests] = new_sel ^ model_sel;
        model_sel = new_sel;
        cmd_words.push_back(random_word());
        cmd_words.push_back(SELECT_CLOCK);
        cmd_words.push_back(w);
        close_test();
    endtask

    task automatic build_table();
        int n;
        n = ($unsigned($random(seed)) % ECHO_DEPTH) + 1;
        add_status_test("dirchan_read", DIRCHAN_READ, DIRCHAN_REPORT, dirchan);
        add_status_test("aovf_read", AOVF_READ, AOVF_REPORT, aovf);
        add_echo_test("echo_random", n);
        add_echo_test("echo_full", ECHO_DEPTH);
        add_select_test("select_clock_first");
        add_echo_test("echo_after_switch", ($unsigned($random(seed)) % ECHO_DEPTH) + 1);
        add_select_test("select_clock_second");
        open_test("unknown_cmd", KIND_SILENT);
        cmd_words.push_back(random_word());
        cmd_words.push_back(16'h0055);
        close_test();
    endtask

    task automatic send_words(input int t);
        for (int j = 0; j < cmd_len[t]; j++) begin
            @(posedge cr_core);
            in_valid <= 1'b1;
            in_data <= cmd_words[cmd_base[t] + j];
        end
        @(posedge cr_core);
        in_valid <= 1'b0;
        in_data <= '0;
    endtask

    // Starts right after the edge that samples the last command word
    task automatic check_report(input int t);
        int lat;
        @(negedge cr_core);
        lat = 1;
        while (!out_valid) begin
            @(negedge cr_core);
            lat++;
        end
        assert (lat == 2) else report_mismatch("first word latency", 2, lat);
        for (int j = 0; j < exp_len[t]; j++) begin
            if (j > 0) begin
                @(negedge cr_core);
            end
            assert (out_valid) else report_error("report words not on consecutive cycles");
            assert (out_data == exp_words[exp_base[t] + j])
                else report_mismatch($sformatf("word %0d", j), exp_words[exp_base[t] + j],
                                     out_data);
        end
        @(negedge cr_core);
        assert (!out_valid) else report_error("report longer than expected");
    endtask

    task automatic check_silent();
        repeat (50) begin
            @(negedge cr_core);
            assert (!out_valid) else report_error("report sent for an unknown command");
        end
    endtask

    task automatic check_follow(input slot_mask_t sel);
        slot_mask_t exp_clk;
        repeat (FOLLOW_CYCLES) begin
            @(negedge cr_core);
            for (int i = 0; i < NUM_SLOTS; i++) begin
                exp_clk[i] = sel[i] ? clk1 : clk0;
            end
            assert (slot_clk == exp_clk) else report_mismatch("slot_clk", exp_clk, slot_clk);
            assert (slot_reset == '0) else report_mismatch("slot_reset", 0, slot_reset);
        end
    endtask

    task automatic check_reset_release();
        logic seen0;
        logic p0;
        assert (!out_valid) else report_error("out_valid high after reset");
        assert (slot_reset == '1) else report_mismatch("slot_reset after reset", 4'hf,
                                                       slot_reset);
        seen0 = 1'b0;
        p0 = clk0;
        while (slot_reset != '0) begin
            @(negedge cr_core);
            assert (slot_reset == '0 || slot_reset == '1)
                else report_error("slots left reset on different cycles");
            if (slot_reset == '0) begin
                assert (seen0) else report_error("slot reset released before a clk0 edge");
            end
            if (clk0 && !p0) begin
                seen0 = 1'b1;
            end
            p0 = clk0;
        end
        check_follow('0);
    endtask

    task automatic check_switch(input int t);
        slot_mask_t chg;
        slot_mask_t sel;
        slot_mask_t seen;
        slot_mask_t exp_clk;
        logic p0;
        logic p1;
        logic r0;
        logic r1;
        chg = tchg[t];
        sel = tsel[t];
        @(negedge cr_core);
        while (slot_reset == '0) begin
            @(negedge cr_core);
        end
        assert (slot_reset == chg) else report_mismatch("slot_reset on switch", chg, slot_reset);
        assert ((slot_clk & chg) == '0) else report_error("switched slot clock not held low");
        seen = '0;
        p0 = clk0;
        p1 = clk1;
        while (slot_reset != '0) begin
            @(negedge cr_core);
            assert ((slot_reset & ~chg) == '0)
                else report_mismatch("unchanged slot reset", 0, slot_reset);
            // The gap lasts one cycle, after it every slot runs on its selected clock
            for (int i = 0; i < NUM_SLOTS; i++) begin
                exp_clk[i] = sel[i] ? clk1 : clk0;
            end
            assert (slot_clk == exp_clk)
                else report_mismatch("slot_clk during release", exp_clk, slot_clk);
            for (int i = 0; i < NUM_SLOTS; i++) begin
                if (chg[i] && !slot_reset[i]) begin
                    assert (seen[i]) else report_error("slot left reset before its new clock rose");
                end
            end
            r0 = clk0 && !p0;
            r1 = clk1 && !p1;
            for (int i = 0; i < NUM_SLOTS; i++) begin
                if (sel[i] ? r1 : r0) begin
                    seen[i] = 1'b1;
                end
            end
            p0 = clk0;
            p1 = clk1;
        end
        check_follow(sel);
    endtask

    initial begin
        in_valid = 1'b0;
        in_data = '0;
        dirchan = 8'($random(seed));
        aovf = 8'($random(seed));
        build_table();
        limit = 20 * cmd_words.size() + 500;
        @(negedge cr_core);
        while (!rst_n) begin
            @(negedge cr_core);
        end
        check_reset_release();
        for (int t = 0; t < n_tests; t++) begin
            cur_name = tname[t];
            send_words(t);
            case (tkind[t])
                KIND_REPORT: check_report(t);
                KIND_SELECT: check_switch(t);
                default: check_silent();
            endcase
            repeat (3) @(posedge cr_core);
        end
        $display("sim passed");
        $finish;
    end

endmodule

// ==== source/clock_select_regs.sv ====
//**********************************************************************
// Clock select register
// Holds the per-slot clock select and pulses the flipped bits
//**********************************************************************

`timescale 1ns/1ps

module clock_select_regs import da_pkg::*; (
    input  logic        cr_core,
    input  logic        rst_n,
    input  logic        clksel_wr,
    input  slot_mask_t  clksel_wdata,
    output slot_mask_t  clksel,
    output slot_mask_t  change
);

    always_ff @(posedge cr_core) begin
        if (!rst_n) begin
            clksel <= '0;
            change <= '0;
        end else begin
            if (clksel_wr) begin
                // Only slots whose source actually moves get a change pulse
                change <= clksel ^ clksel_wdata;
                clksel <= clksel_wdata;
            end else begin
                change <= '0;
            end
        end
    end

endmodule

// ==== source/da_core.sv ====
//**********************************************************************
// DA control core top level
// Host command parser, echo FIFO, report framer and slot clocking
//**********************************************************************

`timescale 1ns/1ps

module da_core import da_pkg::*; (
    input  logic        cr_core,
    input  logic        rst_n,
    input  logic        in_valid,
    input  host_word_t  in_data,
    input  logic [7:0]  dirchan,
    input  logic [7:0]  aovf,
    input  logic        clk0,
    input  logic        clk1,
    output logic        out_valid,
    output host_word_t  out_data,
    output slot_mask_t  slot_clk,
    output slot_mask_t  slot_reset
);

    logic           busy;
    logic           rpt_req;
    host_word_t     rpt_slot;
    host_word_t     rpt_code;
    report_len_t    rpt_len;
    logic [7:0]     rpt_status;
    logic           echo_push;
    host_word_t     echo_wdata;
    logic           echo_pop;
    host_word_t     echo_head;
    logic           empty;
    logic           clksel_wr;
    slot_mask_t     clksel_wdata;
    slot_mask_t     clksel;
    slot_mask_t     change;

    host_cmd_parser u_parser (
        .cr_core      (cr_core),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_data      (in_data),
        .busy         (busy),
        .dirchan      (dirchan),
        .aovf         (aovf),
        .rpt_req      (rpt_req),
        .rpt_slot     (rpt_slot),
        .rpt_code     (rpt_code),
        .rpt_len      (rpt_len),
        .rpt_status   (rpt_status),
        .echo_push    (echo_push),
        .echo_wdata   (echo_wdata),
        .clksel_wr    (clksel_wr),
        .clksel_wdata (clksel_wdata)
    );

    echo_fifo #(.depth(ECHO_DEPTH)) u_echo_fifo (
        .cr_core    (cr_core),
        .rst_n      (rst_n),
        .echo_push  (echo_push),
        .echo_wdata (echo_wdata),
        .echo_pop   (echo_pop),
        .echo_head  (echo_head),
        .empty      (empty)
    );

    report_framer u_framer (
        .cr_core    (cr_core),
        .rst_n      (rst_n),
        .rpt_req    (rpt_req),
        .rpt_slot   (rpt_slot),
        .rpt_code   (rpt_code),
        .rpt_len    (rpt_len),
        .rpt_status (rpt_status),
        .echo_head  (echo_head),
        .empty      (empty),
        .busy       (busy),
        .echo_pop   (echo_pop),
        .out_valid  (out_valid),
        .out_data   (out_data)
    );

    clock_select_regs u_clksel (
        .cr_core      (cr_core),
        .rst_n        (rst_n),
        .clksel_wr    (clksel_wr),
        .clksel_wdata (clksel_wdata),
        .clksel       (clksel),
        .change       (change)
    );

    slot_clock_ctrl u_slot_clk (
        .cr_core    (cr_core),
        .rst_n      (rst_n),
        .clksel     (clksel),
        .change     (change),
        .clk0       (clk0),
        .clk1       (clk1),
        .slot_clk   (slot_clk),
        .slot_reset (slot_reset)
    );

endmodule

// ==== source/da_pkg.sv ====
//**********************************************************************
// DA control core shared definitions
// Host word and slot widths, command and report codes,
// report framing constants and common types
//**********************************************************************

package da_pkg;

    localparam int HOST_WIDTH = 16;
    localparam int NUM_SLOTS = 4;

    typedef logic [HOST_WIDTH-1:0] host_word_t;
    typedef logic [NUM_SLOTS-1:0] slot_mask_t;

    // Echo payload runs from 1 to ECHO_DEPTH words
    localparam int ECHO_DEPTH = 16;
    localparam int ECHO_CNT_W = $clog2(ECHO_DEPTH + 1);

    // Report framing
    localparam int HEADER_WORDS = 4;
    localparam int CHECKSUM_WORDS = 2;
    localparam int CHECKSUM_WIDTH = HOST_WIDTH * CHECKSUM_WORDS;

    typedef logic [23:0] report_len_t;

    // Host commands
    localparam host_word_t DIRCHAN_READ = 16'h0091;
    localparam host_word_t AOVF_READ = 16'h0092;
    localparam host_word_t SELECT_CLOCK = 16'h0093;
    localparam host_word_t ECHO_SEND = 16'h00A0;

    // Reports sent back to the host
    localparam host_word_t DIRCHAN_REPORT = 16'h0081;
    localparam host_word_t AOVF_REPORT = 16'h0082;
    localparam host_word_t ECHO_REPORT = 16'h00B0;

    // Slot word of reports that concern the whole board
    localparam host_word_t GLOBAL_TARGET_INDEX = 16'h00FF;

endpackage

// ==== source/echo_fifo.sv ====
//**********************************************************************
// Echo payload FIFO
// Small circular buffer with the head word shown without latency
//**********************************************************************

`timescale 1ns/1ps

module echo_fifo import da_pkg::*; #(
    parameter int depth = ECHO_DEPTH
) (
    input  logic        cr_core,
    input  logic        rst_n,
    input  logic        echo_push,
    input  host_word_t  echo_wdata,
    input  logic        echo_pop,
    output host_word_t  echo_head,
    output logic        empty
);

    localparam int PTR_W = (depth > 1) ? $clog2(depth) : 1;
    localparam int CNT_W = $clog2(depth + 1);

    host_word_t         mem [depth];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               full;

    assign empty = (count == '0);
    assign full = (count == CNT_W'(depth));
    assign echo_head = mem[rd_ptr];

    always_ff @(posedge cr_core) begin
        if (echo_push) begin
            mem[wr_ptr] <= echo_wdata;
        end
    end

    always_ff @(posedge cr_core) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (echo_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (echo_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(echo_push) - CNT_W'(echo_pop);
        end
    end

    a_no_overflow: assert property (@(posedge cr_core) disable iff (!rst_n)
        full |-> !echo_push);
    a_no_underflow: assert property (@(posedge cr_core) disable iff (!rst_n)
        empty |-> !echo_pop);

endmodule

// ==== source/host_cmd_parser.sv ====
//**********************************************************************
// Host command parser
// Decodes slot, command and data words of each host packet,
// fills the echo FIFO, writes the clock select and requests reports
//**********************************************************************

`timescale 1ns/1ps

module host_cmd_parser import da_pkg::*; (
    input  logic                cr_core,
    input  logic                rst_n,
    input  logic                in_valid,
    input  host_word_t          in_data,
    input  logic                busy,
    input  logic [7:0]          dirchan,
    input  logic [7:0]          aovf,
    output logic                rpt_req,
    output host_word_t          rpt_slot,
    output host_word_t          rpt_code,
    output report_len_t         rpt_len,
    output logic [7:0]          rpt_status,
    output logic                echo_push,
    output host_word_t          echo_wdata,
    output logic                clksel_wr,
    output slot_mask_t          clksel_wdata
);

    typedef enum logic [1:0] {
        IDLE,
        COMMAND,
        DATA
    } state_t;

    state_t                 state;
    host_word_t             slot_q;
    host_word_t             cmd_q;
    logic                   have_count;
    logic [ECHO_CNT_W-1:0]  echo_total;
    logic [ECHO_CNT_W-1:0]  word_cnt;
    logic                   accept;

    // Our own pending request counts as busy until the framer takes it
    assign accept = in_valid && !busy && !rpt_req;

    always_ff @(posedge cr_core) begin
        if (!rst_n) begin
            state <= IDLE;
            rpt_req <= 1'b0;
            echo_push <= 1'b0;
            clksel_wr <= 1'b0;
            have_count <= 1'b0;
        end else begin
            rpt_req <= 1'b0;
            echo_push <= 1'b0;
            clksel_wr <= 1'b0;
            if (accept) begin
                case (state)
                    IDLE: begin
                        slot_q <= in_data;
                        state <= COMMAND;
                    end
                    COMMAND: begin
                        cmd_q <= in_data;
                        have_count <= 1'b0;
                        state <= IDLE;
                        case (in_data)
                            DIRCHAN_READ, AOVF_READ: begin
                                rpt_req <= 1'b1;
                                rpt_slot <= GLOBAL_TARGET_INDEX;
                                rpt_len <= report_len_t'(1);
                                if (in_data == DIRCHAN_READ) begin
                                    rpt_code <= DIRCHAN_REPORT;
                                    rpt_status <= dirchan;
                                end else begin
                                    rpt_code <= AOVF_REPORT;
                                    rpt_status <= aovf;
                                end
                            end
                            ECHO_SEND, SELECT_CLOCK: begin
                                state <= DATA;
                            end
                            // Unknown commands are dropped without a report
                            default: begin
                                state <= IDLE;
                            end
                        endcase
                    end
                    DATA: begin
                        if (cmd_q == SELECT_CLOCK) begin
                            clksel_wr <= 1'b1;
                            clksel_wdata <= in_data[NUM_SLOTS-1:0];
                            state <= IDLE;
                        end else if (!have_count) begin
                            // First data word of an echo is the word count
                            echo_total <= in_data[ECHO_CNT_W-1:0];
                            word_cnt <= '0;
                            have_count <= 1'b1;
                            if (in_data == '0) begin
                                state <= IDLE;
                            end
                        end else begin
                            echo_push <= 1'b1;
                            echo_wdata <= in_data;
                            word_cnt <= word_cnt + 1'b1;
                            if (word_cnt + 1'b1 == echo_total) begin
                                rpt_req <= 1'b1;
                                rpt_slot <= slot_q;
                                rpt_code <= ECHO_REPORT;
                                rpt_len <= report_len_t'(echo_total);
                                state <= IDLE;
                            end
                        end
                    end
                    default: begin
                        state <= IDLE;
                    end
                endcase
            end
        end
    end

    // A new report may only start once the framer has finished the last one
    a_req_not_busy: assert property (@(posedge cr_core) disable iff (!rst_n)
        $rose(rpt_req) |-> !busy);

endmodule

// ==== source/report_framer.sv ====
//**********************************************************************
// Report framer
// Sends header, payload and 32-bit checksum footer of each report
// as a word strobe, pulling echo payload from the echo FIFO
//**********************************************************************

`timescale 1ns/1ps

module report_framer import da_pkg::*; (
    input  logic        cr_core,
    input  logic        rst_n,
    input  logic        rpt_req,
    input  host_word_t  rpt_slot,
    input  host_word_t  rpt_code,
    input  report_len_t rpt_len,
    input  logic [7:0]  rpt_status,
    input  host_word_t  echo_head,
    input  logic        empty,
    output logic        busy,
    output logic        echo_pop,
    output logic        out_valid,
    output host_word_t  out_data
);

    localparam int IDX_W = $bits(report_len_t) + 1;

    logic                       active;
    logic                       start;
    logic [IDX_W-1:0]           idx;
    logic [IDX_W-1:0]           pay_end;
    logic                       in_payload;
    logic                       last_word;
    host_word_t                 code_q;
    report_len_t                len_q;
    logic [7:0]                 status_q;
    logic [CHECKSUM_WIDTH-1:0]  csum;
    host_word_t                 next_word;

    // Busy covers the request cycle's follow-up until the last word is out
    assign busy = active || out_valid;
    assign start = rpt_req && !busy;

    // Word index of the first footer word
    assign pay_end = IDX_W'(HEADER_WORDS) + IDX_W'(len_q);

    always_comb begin
        in_payload = (idx >= IDX_W'(HEADER_WORDS)) && (idx < pay_end);
        last_word = (idx == pay_end + IDX_W'(CHECKSUM_WORDS - 1));
        echo_pop = active && in_payload && (code_q == ECHO_REPORT);
        case (idx)
            IDX_W'(1): next_word = code_q;
            IDX_W'(2): next_word = host_word_t'(len_q[23:16]);
            IDX_W'(3): next_word = len_q[15:0];
            default: begin
                if (in_payload) begin
                    if (code_q == ECHO_REPORT) begin
                        next_word = echo_head;
                    end else begin
                        next_word = host_word_t'(status_q);
                    end
                end else if (idx == pay_end) begin
                    next_word = csum[CHECKSUM_WIDTH-1 -: HOST_WIDTH];
                end else begin
                    next_word = csum[HOST_WIDTH-1:0];
                end
            end
        endcase
    end

    always_ff @(posedge cr_core) begin
        if (!rst_n) begin
            active <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= active || start;
            if (active && last_word) begin
                active <= 1'b0;
            end else if (start) begin
                active <= 1'b1;
            end
        end
    end

    // Word 0 goes out straight from the request, the rest from the latched copy
    always_ff @(posedge cr_core) begin
        if (start) begin
            out_data <= rpt_slot;
            code_q <= rpt_code;
            len_q <= rpt_len;
            status_q <= rpt_status;
            idx <= IDX_W'(1);
            csum <= CHECKSUM_WIDTH'(rpt_slot);
        end else if (active) begin
            out_data <= next_word;
            idx <= idx + 1'b1;
            if (idx < pay_end) begin
                csum <= csum + CHECKSUM_WIDTH'(next_word);
            end
        end
    end

    // Echo data is fully buffered by the parser before its report starts
    a_echo_ready: assert property (@(posedge cr_core) disable iff (!rst_n)
        echo_pop |-> !empty);

endmodule

// ==== source/slot_clock_ctrl.sv ====
//**********************************************************************
// Slot clock control
// Gates each slot clock from clk0 or clk1 and holds a slot in reset
// after a switch until its new clock shows a rising edge
//**********************************************************************

`timescale 1ns/1ps

module slot_clock_ctrl import da_pkg::*; (
    input  logic        cr_core,
    input  logic        rst_n,
    input  slot_mask_t  clksel,
    input  slot_mask_t  change,
    input  logic        clk0,
    input  logic        clk1,
    output slot_mask_t  slot_clk,
    output slot_mask_t  slot_reset
);

    logic       clk0_q;
    logic       clk1_q;
    logic       rise0;
    logic       rise1;
    slot_mask_t inhibit;

    // Previous samples of the slow clocks for edge detection
    always_ff @(posedge cr_core) begin
        clk0_q <= clk0;
        clk1_q <= clk1;
    end

    assign rise0 = clk0 && !clk0_q;
    assign rise1 = clk1 && !clk1_q;

    always_ff @(posedge cr_core) begin
        if (!rst_n) begin
            inhibit <= '0;
            slot_reset <= '1;
        end else begin
            inhibit <= change;
            for (int i = 0; i < NUM_SLOTS; i++) begin
                if (change[i]) begin
                    slot_reset[i] <= 1'b1;
                end else if (slot_reset[i] && !inhibit[i]) begin
                    // Release on the first edge of the selected source
                    if (clksel[i] ? rise1 : rise0) begin
                        slot_reset[i] <= 1'b0;
                    end
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_SLOTS; i++) begin
            slot_clk[i] = !inhibit[i] && (clksel[i] ? clk1 : clk0);
        end
    end

    // A change pulse flags exactly the slots whose select just moved
    a_change_matches_sel: assert property (@(posedge cr_core) disable iff (!rst_n)
        change == (clksel ^ $past(clksel)));

endmodule
